// File: hdl/adc_uart_pkg.sv
// ====================================================================
// Shared widths, types and constants of the ADC to UART design
// Imported by every RTL module with a wildcard import
// ====================================================================

package adc_uart_pkg;

	// ================================================================
	// LTC2308 ADC
	// ================================================================
	localparam int ADC_BITS = 12;
	typedef logic [ADC_BITS-1:0] adc_sample_t;

	localparam int ADC_CFG_BITS = 6;
	// S/D=1, O/S=0, S1=0, S0=0, UNI=1, SLP=0 selects single-ended channel 0
	localparam logic [ADC_CFG_BITS-1:0] ADC_CONFIG_WORD = 6'b100010;

	// Conversion takes up to 1.6 us, i.e. 80 cycles of a 50 MHz clock
	localparam int TCONV_CYCLES = 80;

	// ================================================================
	// APB and UART register map
	// ================================================================
	localparam int APB_ADDR_BITS = 32;
	localparam int APB_DATA_BITS = 32;
	typedef logic [APB_ADDR_BITS-1:0] apb_addr_t;
	typedef logic [APB_DATA_BITS-1:0] apb_data_t;

	typedef enum logic [7:0] {
		UART_THR = 8'h00,
		UART_LSR = 8'h14
	} uart_reg_e;

	// Set when the transmit holding register can take a byte
	localparam int LSR_THRE_BIT = 5;

	// ================================================================
	// Message text
	// ================================================================
	typedef logic [7:0] byte_t;

	localparam int MSG_LEN = 12;
	localparam logic [47:0] MSG_PREFIX = "ch0=0x";
	localparam byte_t ASCII_CR = 8'h0D;
	localparam byte_t ASCII_LF = 8'h0A;

endpackage

// File: hdl/adc_sampler.sv
// ====================================================================
// LTC2308 serial engine, one channel 0 conversion per sample_request
// ====================================================================

`timescale 1ns/100ps

module adc_sampler import adc_uart_pkg::*; (
	input  logic        pll0_clock0,
	input  logic        my_reset,
	input  logic        sample_request,
	input  logic        adc_sdo,
	output logic        sample_valid,
	output adc_sample_t sample_data,
	output logic        adc_convst,
	output logic        adc_sck,
	output logic        adc_sdi
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_CONVERT,
		S_WAIT,
		S_SHIFT
	} sampler_state_e;

	localparam int WAIT_W = $clog2(TCONV_CYCLES);
	localparam int BIT_W  = $clog2(ADC_BITS);

	sampler_state_e          state;
	logic [WAIT_W-1:0]       wait_cnt;
	logic [BIT_W-1:0]        bit_cnt;
	logic [ADC_CFG_BITS-1:0] cfg_shift;
	adc_sample_t             rx_shift;

	// CONVST is a single cycle pulse from the convert state
	assign adc_convst  = (state == S_CONVERT);
	// Config word leaves MSB first, zeros after the sixth bit
	assign adc_sdi     = cfg_shift[ADC_CFG_BITS-1];
	assign sample_data = rx_shift;

	always_ff @(posedge pll0_clock0 or posedge my_reset) begin
		if (my_reset) begin
			state        <= S_IDLE;
			wait_cnt     <= '0;
			bit_cnt      <= '0;
			cfg_shift    <= '0;
			adc_sck      <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (sample_request) begin
						state <= S_CONVERT;
					end
				end
				S_CONVERT: begin
					wait_cnt <= '0;
					state    <= S_WAIT;
				end
				S_WAIT: begin
					if (wait_cnt == WAIT_W'(TCONV_CYCLES - 1)) begin
						bit_cnt   <= '0;
						cfg_shift <= ADC_CONFIG_WORD;
						state     <= S_SHIFT;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				S_SHIFT: begin
					// Two clocks per SCK period, low half first
					if (!adc_sck) begin
						adc_sck <= 1'b1;
					end else begin
						adc_sck   <= 1'b0;
						cfg_shift <= {cfg_shift[ADC_CFG_BITS-2:0], 1'b0};
						if (bit_cnt == BIT_W'(ADC_BITS - 1)) begin
							sample_valid <= 1'b1;
							state        <= S_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// SDO is taken at the end of the high half, MSB first
	always_ff @(posedge pll0_clock0) begin
		if (state == S_SHIFT && adc_sck) begin
			rx_shift <= {rx_shift[ADC_BITS-2:0], adc_sdo};
		end
	end

endmodule

// File: hdl/message_builder.sv
// ====================================================================
// Paces sample requests and turns each sample into one 12 byte line
// ====================================================================

`timescale 1ns/100ps

module message_builder import adc_uart_pkg::*; #(
	parameter int SAMPLE_INTERVAL = 2**25
) (
	input  logic        pll0_clock0,
	input  logic        my_reset,
	input  logic        sample_valid,
	input  adc_sample_t sample_data,
	input  logic        full,
	output logic        sample_request,
	output logic        push,
	output byte_t       push_data
);

	typedef enum logic [1:0] {
		B_INTERVAL,
		B_WAIT_SAMPLE,
		B_PUSH
	} builder_state_e;

	localparam int CNT_W      = $clog2(SAMPLE_INTERVAL + 1);
	localparam int IDX_W      = $clog2(MSG_LEN);
	localparam int PREFIX_LEN = $bits(MSG_PREFIX) / 8;
	localparam int HEX_DIGITS = 4;

	// Sample widened to 16 bits, so the top digit reads 0
	typedef logic [4*HEX_DIGITS-1:0] hex_word_t;

	builder_state_e   state;
	logic [CNT_W-1:0] interval_cnt;
	logic [IDX_W-1:0] byte_idx;
	hex_word_t        sample_word;
	int               digit_idx;

	function automatic byte_t hex_char(input logic [3:0] nibble);
		if (nibble < 4'd10) begin
			return 8'h30 + {4'h0, nibble};
		end
		return 8'h37 + {4'h0, nibble};
	endfunction

	always_ff @(posedge pll0_clock0 or posedge my_reset) begin
		if (my_reset) begin
			state          <= B_INTERVAL;
			interval_cnt   <= '0;
			byte_idx       <= '0;
			sample_request <= 1'b0;
		end else begin
			sample_request <= 1'b0;
			case (state)
				B_INTERVAL: begin
					if (interval_cnt == CNT_W'(SAMPLE_INTERVAL - 1)) begin
						interval_cnt   <= '0;
						sample_request <= 1'b1;
						state          <= B_WAIT_SAMPLE;
					end else begin
						interval_cnt <= interval_cnt + 1'b1;
					end
				end
				B_WAIT_SAMPLE: begin
					if (sample_valid) begin
						byte_idx <= '0;
						state    <= B_PUSH;
					end
				end
				B_PUSH: begin
					// Stall on a full FIFO, the byte stays on push_data
					if (!full) begin
						if (byte_idx == IDX_W'(MSG_LEN - 1)) begin
							state <= B_INTERVAL;
						end else begin
							byte_idx <= byte_idx + 1'b1;
						end
					end
				end
				default: state <= B_INTERVAL;
			endcase
		end
	end

	always_ff @(posedge pll0_clock0) begin
		if (state == B_WAIT_SAMPLE && sample_valid) begin
			sample_word <= hex_word_t'(sample_data);
		end
	end

	assign push = (state == B_PUSH);

	// Byte select: prefix, hex digits, then CR LF
	always_comb begin
		digit_idx = int'(byte_idx) - PREFIX_LEN;
		if (int'(byte_idx) < PREFIX_LEN) begin
			push_data = MSG_PREFIX[8*(PREFIX_LEN-1-int'(byte_idx)) +: 8];
		end else if (digit_idx < HEX_DIGITS) begin
			push_data = hex_char(sample_word[4*(HEX_DIGITS-1-digit_idx) +: 4]);
		end else if (int'(byte_idx) == MSG_LEN - 2) begin
			push_data = ASCII_CR;
		end else begin
			push_data = ASCII_LF;
		end
	end

endmodule

// File: hdl/byte_fifo.sv
// ====================================================================
// Synchronous byte FIFO between the line formatter and the UART writer
// ====================================================================

`timescale 1ns/100ps

module byte_fifo import adc_uart_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic  pll0_clock0,
	input  logic  my_reset,
	input  logic  push,
	input  byte_t push_data,
	input  logic  pop,
	output byte_t pop_data,
	output logic  full,
	output logic  empty
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	byte_t          mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign full     = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign empty    = (count == '0);
	// Head byte is always visible
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge pll0_clock0 or posedge my_reset) begin
		if (my_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Pointers wrap on their own, depth is a power of two
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge pll0_clock0) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

// File: hdl/uart_apb_writer.sv
// ====================================================================
// APB master that polls the UART line status and writes each byte
// ====================================================================

`timescale 1ns/100ps

module uart_apb_writer import adc_uart_pkg::*; #(
	parameter apb_addr_t UART_BASE_ADDR = 32'hFFC0_2000
) (
	input  logic      pll0_clock0,
	input  logic      my_reset,
	input  logic      empty,
	input  byte_t     pop_data,
	input  apb_data_t prdata,
	input  logic      pready,
	output logic      pop,
	output apb_addr_t paddr,
	output logic      psel,
	output logic      penable,
	output logic      pwrite,
	output apb_data_t pwdata
);

	typedef enum logic [2:0] {
		A_IDLE,
		A_STAT_SETUP,
		A_STAT_ACCESS,
		A_WRITE_SETUP,
		A_WRITE_ACCESS
	} apb_state_e;

	localparam apb_addr_t THR_ADDR = UART_BASE_ADDR + apb_addr_t'(UART_THR);
	localparam apb_addr_t LSR_ADDR = UART_BASE_ADDR + apb_addr_t'(UART_LSR);

	apb_state_e state;
	logic       thr_empty;

	assign thr_empty = prdata[LSR_THRE_BIT];

	always_ff @(posedge pll0_clock0 or posedge my_reset) begin
		if (my_reset) begin
			state <= A_IDLE;
		end else begin
			case (state)
				A_IDLE: begin
					if (!empty) begin
						state <= A_STAT_SETUP;
					end
				end
				A_STAT_SETUP: state <= A_STAT_ACCESS;
				A_STAT_ACCESS: begin
					// Busy transmitter means another LSR read
					if (pready) begin
						state <= thr_empty ? A_WRITE_SETUP : A_STAT_SETUP;
					end
				end
				A_WRITE_SETUP: state <= A_WRITE_ACCESS;
				A_WRITE_ACCESS: begin
					if (pready) begin
						state <= A_IDLE;
					end
				end
				default: state <= A_IDLE;
			endcase
		end
	end

	// ================================================================
	// Bus outputs decoded from the state
	// ================================================================
	assign psel    = (state != A_IDLE);
	assign penable = (state == A_STAT_ACCESS) || (state == A_WRITE_ACCESS);
	assign pwrite  = (state == A_WRITE_SETUP) || (state == A_WRITE_ACCESS);
	assign paddr   = pwrite ? THR_ADDR : LSR_ADDR;
	// Head byte holds still until the pop, so pwdata is stable
	assign pwdata  = pwrite ? apb_data_t'(pop_data) : '0;

	// Byte leaves the FIFO when its THR write completes
	assign pop = (state == A_WRITE_ACCESS) && pready;

endmodule

// File: hdl/adc_uart_top.sv
// ====================================================================
// Top level: ADC sampler, line builder, byte FIFO and APB UART writer
// ====================================================================

`timescale 1ns/100ps

module adc_uart_top import adc_uart_pkg::*; #(
	parameter apb_addr_t UART_BASE_ADDR  = 32'hFFC0_2000,
	parameter int        SAMPLE_INTERVAL = 2**25,
	parameter int        FIFO_DEPTH      = 16
) (
	input  logic      pll0_clock0,
	input  logic      my_reset,
	input  logic      adc_sdo,
	input  apb_data_t prdata,
	input  logic      pready,
	output logic      adc_convst,
	output logic      adc_sck,
	output logic      adc_sdi,
	output apb_addr_t paddr,
	output logic      psel,
	output logic      penable,
	output logic      pwrite,
	output apb_data_t pwdata
);

	// Sampler to builder
	logic        sample_request;
	logic        sample_valid;
	adc_sample_t sample_data;

	// Builder to FIFO to writer
	logic  push;
	byte_t push_data;
	logic  full;
	logic  pop;
	byte_t pop_data;
	logic  empty;

	adc_sampler u_sampler (
		.pll0_clock0    (pll0_clock0),
		.my_reset       (my_reset),
		.sample_request (sample_request),
		.adc_sdo        (adc_sdo),
		.sample_valid   (sample_valid),
		.sample_data    (sample_data),
		.adc_convst     (adc_convst),
		.adc_sck        (adc_sck),
		.adc_sdi        (adc_sdi)
	);

	message_builder #(
		.SAMPLE_INTERVAL (SAMPLE_INTERVAL)
	) u_builder (
		.pll0_clock0    (pll0_clock0),
		.my_reset       (my_reset),
		.sample_valid   (sample_valid),
		.sample_data    (sample_data),
		.full           (full),
		.sample_request (sample_request),
		.push           (push),
		.push_data      (push_data)
	);

	byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.pll0_clock0 (pll0_clock0),
		.my_reset    (my_reset),
		.push        (push),
		.push_data   (push_data),
		.pop         (pop),
		.pop_data    (pop_data),
		.full        (full),
		.empty       (empty)
	);

	uart_apb_writer #(
		.UART_BASE_ADDR (UART_BASE_ADDR)
	) u_writer (
		.pll0_clock0 (pll0_clock0),
		.my_reset    (my_reset),
		.empty       (empty),
		.pop_data    (pop_data),
		.prdata      (prdata),
		.pready      (pready),
		.pop         (pop),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata)
	);

endmodule

// File: tests/adc_uart_properties.sv
// ====================================================================
// APB and LTC2308 pin assertions, bound into the writer and the sampler
// ====================================================================

`timescale 1ns/100ps

module adc_uart_properties (
	input logic        pll0_clock0,
	input logic        my_reset,
	input logic        psel,
	input logic        penable,
	input logic        pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	input logic        pready,
	input logic        adc_sck,
	input logic        adc_sdi
);

	// Setup phase lasts exactly one cycle
	setup_then_access: assert property (
		@(posedge pll0_clock0) disable iff (my_reset)
		psel && !penable |=> psel && penable
	) else $error("APB setup phase not followed by an access phase");

	access_after_setup: assert property (
		@(posedge pll0_clock0) disable iff (my_reset)
		$rose(penable) |-> $past(psel && !penable)
	) else $error("APB access phase entered without a setup phase");

	// Transfer held while the slave inserts wait states
	stable_while_waiting: assert property (
		@(posedge pll0_clock0) disable iff (my_reset)
		psel && penable && !pready |=>
			penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)
	) else $error("APB address, direction or data changed during wait states");

	sdi_changes_with_sck_low: assert property (
		@(posedge pll0_clock0) disable iff (my_reset)
		adc_sdi != $past(adc_sdi) |-> !adc_sck
	) else $error("ADC SDI changed while SCK was high");

endmodule

bind uart_apb_writer adc_uart_properties apb_checks (
	.pll0_clock0 (pll0_clock0),
	.my_reset    (my_reset),
	.psel        (psel),
	.penable     (penable),
	.pwrite      (pwrite),
	.paddr       (paddr),
	.pwdata      (pwdata),
	.pready      (pready),
	.adc_sck     (1'b0),
	.adc_sdi     (1'b0)
);

bind adc_sampler adc_uart_properties pin_checks (
	.pll0_clock0 (pll0_clock0),
	.my_reset    (my_reset),
	.psel        (1'b0),
	.penable     (1'b0),
	.pwrite      (1'b0),
	.paddr       (32'h0),
	.pwdata      (32'h0),
	.pready      (1'b0),
	.adc_sck     (adc_sck),
	.adc_sdi     (adc_sdi)
);

// File: tests/tb_adc_uart.sv
// ====================================================================
// Testbench for adc_uart_top with an LTC2308 model and an APB UART model
// Trace lines give each ADC value and the busy polls before each byte
// ====================================================================

`timescale 1ns/100ps

module tb_adc_uart;

	localparam logic [31:0] BASE_ADDR   = 32'hFFC0_2000;
	localparam logic [31:0] THR_OFFSET  = 32'h0000_0000;
	localparam logic [31:0] LSR_OFFSET  = 32'h0000_0014;
	localparam logic [5:0]  CONFIG_WORD = 6'b100010;
	localparam int INTERVAL    = 64;
	localparam int DEPTH       = 4;
	localparam int LINE_LEN    = 12;
	localparam int MAX_SAMPLES = 64;
	// Generous bound on CONVST, conversion wait and 12 SCK periods
	localparam int CONV_BUDGET = 128;
	localparam int MAX_WAIT    = 3;

	logic        pll0_clock0 = 1'b0;
	logic        my_reset    = 1'b1;
	logic        adc_sdo     = 1'b0;
	logic [31:0] prdata      = 32'h0;
	logic        pready      = 1'b0;
	logic        adc_convst;
	logic        adc_sck;
	logic        adc_sdi;
	logic [31:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;

	// Even words hold ADC values, odd words the busy poll counts
	logic [15:0] trace_mem [0:2*MAX_SAMPLES-1];
	int          num_samples     = 0;
	int          watchdog_cycles = 0;
	logic        trace_ready     = 1'b0;

	// ADC model state
	int          conv_count  = 0;
	int          sck_rises   = 0;
	logic [11:0] cur_sample  = 12'h0;
	logic [5:0]  cfg_seen    = 6'h0;
	logic        convst_prev = 1'b0;
	logic        sck_prev    = 1'b0;

	// APB UART model state
	logic [7:0]  lfsr          = 8'd73;
	logic        in_access     = 1'b0;
	int          wait_left     = 0;
	int          polls         = 0;
	logic        thre_reported = 1'b0;
	int          bytes_written = 0;

	always #5 pll0_clock0 = ~pll0_clock0;

	adc_uart_top #(
		.UART_BASE_ADDR  (BASE_ADDR),
		.SAMPLE_INTERVAL (INTERVAL),
		.FIFO_DEPTH      (DEPTH)
	) dut (
		.pll0_clock0 (pll0_clock0),
		.my_reset    (my_reset),
		.adc_sdo     (adc_sdo),
		.prdata      (prdata),
		.pready      (pready),
		.adc_convst  (adc_convst),
		.adc_sck     (adc_sck),
		.adc_sdi     (adc_sdi),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata)
	);

	// ================================================================
	// Helpers
	// ================================================================
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Taps 8, 6, 5 and 4 give a maximal length sequence
	function automatic logic [7:0] lfsr_step(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	// Character at position pos of the line for one sample
	function automatic logic [7:0] line_char(input logic [11:0] value, input int pos);
		logic [15:0] word;
		logic [3:0]  nibble;
		word = {4'h0, value};
		case (pos)
			0: return "c";
			1: return "h";
			2: return "0";
			3: return "=";
			4: return "0";
			5: return "x";
			10: return 8'h0D;
			11: return 8'h0A;
			default: begin
				nibble = word[4*(9-pos) +: 4];
				return (nibble < 4'd10) ? "0" + {4'h0, nibble} : "A" + {4'h0, nibble} - 8'd10;
			end
		endcase
	endfunction

	// ================================================================
	// LTC2308 model
	// ================================================================
	always @(negedge pll0_clock0) begin
		if (!my_reset) begin
			if (adc_convst) begin
				check_value(32'(convst_prev), 32'd0, "CONVST longer than one cycle");
				if (conv_count > 0) begin
					check_value(32'(sck_rises), 32'd12, "SCK rising edges per conversion");
				end
				cur_sample = (conv_count < num_samples) ? trace_mem[2*conv_count][11:0] : 12'h0;
				conv_count++;
				sck_rises = 0;
				cfg_seen  = 6'h0;
			end
			if (adc_sck && !sck_prev) begin
				sck_rises++;
				if (sck_rises <= 6) begin
					cfg_seen = {cfg_seen[4:0], adc_sdi};
					if (sck_rises == 6) begin
						check_value(32'(cfg_seen), 32'(CONFIG_WORD), "ADC configuration word");
					end
				end
			end else if (!adc_sck && sck_rises < 12) begin
				// Next result bit goes out during the low half, MSB first
				adc_sdo <= cur_sample[11 - sck_rises];
			end
			convst_prev = adc_convst;
			sck_prev    = adc_sck;
		end
	end

	// ================================================================
	// APB UART model
	// ================================================================
	always @(negedge pll0_clock0) begin
		int line_idx;
		int busy_polls;
		line_idx   = bytes_written / LINE_LEN;
		busy_polls = (line_idx < num_samples) ? int'(trace_mem[2*line_idx+1]) : 0;
		if (my_reset || !(psel && penable)) begin
			in_access = 1'b0;
			pready <= 1'b0;
		end else begin
			if (!in_access) begin
				// Two LFSR bits pick 0 to 3 wait states
				in_access = 1'b1;
				lfsr      = lfsr_step(lfsr);
				wait_left = int'(lfsr[0]);
				lfsr      = lfsr_step(lfsr);
				wait_left = wait_left + 2 * int'(lfsr[0]);
			end
			if (wait_left > 0) begin
				wait_left--;
				pready <= 1'b0;
			end else if (!pwrite) begin
				check_value(paddr, BASE_ADDR + LSR_OFFSET, "LSR read address");
				thre_reported = (polls >= busy_polls);
				prdata <= thre_reported ? 32'h0000_0060 : 32'h0000_0000;
				pready <= 1'b1;
				polls++;
			end else begin
				check_value(paddr, BASE_ADDR + THR_OFFSET, "THR write address");
				check_value(32'(thre_reported), 32'd1, "THR write while transmitter busy");
				check_value(32'(polls), 32'(busy_polls + 1), "LSR reads before THR write");
				check_value(pwdata,
					32'(line_char(trace_mem[2*line_idx][11:0], bytes_written % LINE_LEN)),
					"THR byte");
				pready <= 1'b1;
				polls = 0;
				thre_reported = 1'b0;
				bytes_written++;
			end
		end
	end

	// ================================================================
	// Main sequence and watchdog
	// ================================================================
	initial begin
		int max_busy;
		max_busy = 0;
		for (int i = 0; i < 2*MAX_SAMPLES; i++) begin
			trace_mem[i] = 16'hF000 | 16'(i);
		end
		$readmemh("tests/adc_uart_trace.txt", trace_mem);
		while (num_samples < MAX_SAMPLES && trace_mem[2*num_samples][15:12] != 4'hF) begin
			num_samples++;
		end
		if (num_samples == 0) begin
			$display("The trace file holds no samples");
			$display("*** FAILED ***");
			$fatal(1, "Empty trace");
		end
		for (int i = 0; i < num_samples; i++) begin
			if (int'(trace_mem[2*i+1]) > max_busy) begin
				max_busy = int'(trace_mem[2*i+1]);
			end
		end
		watchdog_cycles = 32 + num_samples *
			(INTERVAL + CONV_BUDGET + LINE_LEN * (max_busy + 2) * (MAX_WAIT + 3));
		trace_ready = 1'b1;

		repeat (16) begin
			@(negedge pll0_clock0);
			check_value(32'({psel, penable, pwrite, adc_convst, adc_sck, adc_sdi}), 32'd0,
				"Outputs during reset");
		end
		my_reset = 1'b0;
		@(negedge pll0_clock0);
		check_value(32'({psel, penable, pwrite, adc_convst, adc_sck, adc_sdi}), 32'd0,
			"Outputs just after reset");

		wait (bytes_written == num_samples * LINE_LEN);
		@(negedge pll0_clock0);
		if (conv_count == num_samples) begin
			check_value(32'(sck_rises), 32'd12, "SCK rising edges in last conversion");
		end
		$display("*** PASSED ***");
		$finish;
	end

	initial begin
		wait (trace_ready);
		repeat (watchdog_cycles) @(posedge pll0_clock0);
		$display("Timeout: not all trace lines reached the UART within %0d cycles",
			watchdog_cycles);
		$display("*** FAILED ***");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: tests/adc_uart_trace.txt
// Columns: ADC sample (12-bit hex), busy LSR polls before each byte of its line (hex)
// One line per sample, in the order the conversions happen
000 0
FFF 2
ABC 1
123 0
7E4 3
08F 0
5A5 1
C3D 0
001 2
800 0
9B6 1
E0F 0
3C7 3
D28 0
46A 1
BEE 0

// File: files.f
hdl/adc_uart_pkg.sv
hdl/adc_sampler.sv
hdl/message_builder.sv
hdl/byte_fifo.sv
hdl/uart_apb_writer.sv
hdl/adc_uart_top.sv
tests/adc_uart_properties.sv
tests/tb_adc_uart.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_adc_uart -Mdir obj_dir
./obj_dir/Vtb_adc_uart | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
